// ==== common/ooo_settings.svh ====
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// Data path width in bits
`define XLEN 32

// Physical register file size
`define NUM_PREGS 64

// Multiply station entries, also the dispatch credits at reset
`define MUL_RS_DEPTH 4

// CDB credits granted at reset
`define CDB_CREDITS 2

// Reorder buffer entries
`define ROB_DEPTH 16

`endif

// ==== common/rv32m_pkg.sv ====
`include "ooo_settings.svh"

package rv32m_pkg;

    // Architectural data word
    typedef logic [`XLEN-1:0] word_t;

    // Full product of two words
    typedef logic [2*`XLEN-1:0] dword_t;

    // M-extension multiply variants
    // MUL returns the low word, the others the high word
    typedef enum logic [1:0] {
        MUL    = 2'b00,
        // signed x signed
        MULH   = 2'b01,
        // signed x unsigned
        MULHSU = 2'b10,
        // unsigned x unsigned
        MULHU  = 2'b11
    } mul_op_e;

endpackage

// ==== common/ooo_pkg.sv ====
`include "ooo_settings.svh"

package ooo_pkg;

    import rv32m_pkg::*;

    // Physical register tag
    typedef logic [$clog2(`NUM_PREGS)-1:0] preg_t;

    // Reorder buffer index
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

    // Renamed multiply as it leaves dispatch
    typedef struct packed {
        mul_op_e  op;
        preg_t    rs1;
        preg_t    rs2;
        preg_t    rd;
        rob_idx_t rob_idx;
    } dispatch_t;

    // Issue from station to functional unit
    // start_calculate marks the single issue cycle
    typedef struct packed {
        logic      start_calculate;
        dispatch_t inst;
    } fu_input_t;

    // Functional unit result, same layout as the CDB payload
    typedef struct packed {
        preg_t    rd;
        rob_idx_t rob_idx;
        word_t    value;
    } cdb_packet_t;

    // Multiply wrapper FSM
    typedef enum logic [1:0] {
        IDLE = 2'b00,
        // Multiplier running
        BUSY = 2'b01,
        // Result waiting for the CDB buffer
        HOLD = 2'b10
    } mul_state_e;

endpackage

// ==== src/phys_regfile.sv ====
`timescale 1ns/1ps
`include "ooo_settings.svh"

module phys_regfile
    import rv32m_pkg::*;
    import ooo_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  we,
    input  preg_t waddr,
    input  word_t wdata,
    input  preg_t raddr1,
    input  preg_t raddr2,
    output word_t rdata1,
    output word_t rdata2
);

    word_t regs [`NUM_PREGS];

    // Single write port, visible to reads one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_PREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Combinational reads, p0 is hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== mul_station/mul_station.sv ====
`timescale 1ns/1ps
`include "ooo_settings.svh"

module mul_station
    import ooo_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      dispatch_valid,
    input  dispatch_t dispatch,
    output logic      dispatch_credit,
    output preg_t     rs1_tag,
    output preg_t     rs2_tag,
    input  logic      fu_ready,
    output fu_input_t issue
);

    localparam int PTR_W = $clog2(`MUL_RS_DEPTH);
    localparam int CNT_W = $clog2(`MUL_RS_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(`MUL_RS_DEPTH - 1);

    // Entries stay in dispatch order, sources are already ready
    dispatch_t entries [`MUL_RS_DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // Sender holds credits, so a valid dispatch always finds room
    assign push = dispatch_valid;
    // Issue oldest entry whenever the unit is free
    assign pop  = (count != '0) && fu_ready;

    // Credit goes back in the same cycle the entry leaves
    assign dispatch_credit = pop;

    // Head entry drives the register file read tags
    assign rs1_tag = entries[head].rs1;
    assign rs2_tag = entries[head].rs2;

    assign issue.start_calculate = pop;
    assign issue.inst            = entries[head];

    always_ff @(posedge clk) begin
        if (push) begin
            entries[tail] <= dispatch;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= (tail == LAST) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == LAST) ? '0 : head + 1'b1;
            end
            // Occupancy
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== mul_fu/shift_add_multiplier.sv ====
`timescale 1ns/1ps
`include "ooo_settings.svh"

module shift_add_multiplier
    import rv32m_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  mul_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   p,
    output logic    done
);

    localparam int CNT_W = $clog2(`XLEN);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`XLEN - 1);

    // Operands widened by one bit so unsigned values keep their range
    logic [`XLEN:0] a_ext;
    logic [`XLEN:0] b_ext;
    logic [`XLEN:0] a_mag;
    logic [`XLEN:0] b_mag;
    logic           a_signed;
    logic           b_signed;

    logic             busy;
    logic [CNT_W-1:0] step;
    mul_op_e          op_q;
    logic             neg_q;
    dword_t           acc;
    dword_t           mcand;
    word_t            mplier;
    dword_t           prod;

    always_comb begin
        // MULHU treats rs1 as unsigned, MULHSU and MULHU treat rs2 that way
        a_signed = (op != MULHU);
        b_signed = (op == MUL) || (op == MULH);
        a_ext    = {a_signed & a[`XLEN-1], a};
        b_ext    = {b_signed & b[`XLEN-1], b};
        // Magnitudes always fit in XLEN bits
        a_mag    = a_ext[`XLEN] ? -a_ext : a_ext;
        b_mag    = b_ext[`XLEN] ? -b_ext : b_ext;
    end

    // Payload path, one add and shift per step
    always_ff @(posedge clk) begin
        if (start) begin
            op_q   <= op;
            neg_q  <= a_ext[`XLEN] ^ b_ext[`XLEN];
            acc    <= '0;
            mcand  <= dword_t'(a_mag[`XLEN-1:0]);
            mplier <= b_mag[`XLEN-1:0];
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Step counter, done follows the last step
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            step <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == LAST_STEP) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Sign correction and word select straight off the accumulator
    assign prod = neg_q ? -acc : acc;
    assign p    = (op_q == MUL) ? prod[`XLEN-1:0] : prod[2*`XLEN-1:`XLEN];

endmodule

// ==== mul_fu/fu_wrapper_mult.sv ====
`timescale 1ns/1ps

module fu_wrapper_mult
    import rv32m_pkg::*;
    import ooo_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  fu_input_t   issue,
    input  word_t       rs1_data,
    input  word_t       rs2_data,
    output logic        fu_ready,
    output logic        res_valid,
    output cdb_packet_t res,
    input  logic        res_accept
);

    mul_state_e state;

    // Instruction and operands captured at issue
    dispatch_t inst_q;
    word_t     a_q;
    word_t     b_q;

    logic  start;
    word_t prod;
    logic  done;

    // Ready is a plain state decode, issue depends on it so it must not
    // depend on start_calculate in turn
    assign fu_ready  = (state == IDLE);
    assign res_valid = (state == HOLD);

    // Operand capture happens in the issue cycle itself
    always_ff @(posedge clk) begin
        if ((state == IDLE) && issue.start_calculate) begin
            inst_q <= issue.inst;
            a_q    <= rs1_data;
            b_q    <= rs2_data;
        end
    end

    // Result register, tagged with the captured destination
    always_ff @(posedge clk) begin
        if ((state == BUSY) && done) begin
            res.rd      <= inst_q.rd;
            res.rob_idx <= inst_q.rob_idx;
            res.value   <= prod;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            start <= 1'b0;
        end else begin
            // Start is a one cycle pulse
            start <= 1'b0;
            case (state)
                IDLE: begin
                    if (issue.start_calculate) begin
                        start <= 1'b1;
                        state <= BUSY;
                    end
                end
                BUSY: begin
                    if (done) begin
                        state <= HOLD;
                    end
                end
                HOLD: begin
                    // Stay busy until the CDB buffer takes it
                    if (res_accept) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    shift_add_multiplier u_mult (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .op    (inst_q.op),
        .a     (a_q),
        .b     (b_q),
        .p     (prod),
        .done  (done)
    );

endmodule

// ==== src/cdb_credit_out.sv ====
`timescale 1ns/1ps
`include "ooo_settings.svh"

module cdb_credit_out
    import ooo_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        res_valid,
    input  cdb_packet_t res,
    output logic        res_accept,
    output logic        cdb_valid,
    output cdb_packet_t cdb,
    input  logic        cdb_credit
);

    localparam int PTR_W = $clog2(`CDB_CREDITS);
    localparam int CNT_W = $clog2(`CDB_CREDITS + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(`CDB_CREDITS - 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(`CDB_CREDITS);

    // One slot per credit, enough to cover the full credit window
    cdb_packet_t fifo_mem [`CDB_CREDITS];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fifo_cnt;
    logic [CNT_W-1:0] credit_cnt;
    logic             push;
    logic             send;

    assign res_accept = (fifo_cnt != FULL);
    assign push       = res_valid && res_accept;
    // Send only with a packet waiting and a credit in hand
    assign send       = (fifo_cnt != '0) && (credit_cnt != '0);

    assign cdb_valid = send;
    assign cdb       = fifo_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= res;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_cnt   <= '0;
            credit_cnt <= FULL;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, send})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;
            endcase
            // Returned credit and a send in the same cycle cancel out
            case ({cdb_credit, send})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

// ==== src/mul_unit_top.sv ====
`timescale 1ns/1ps

module mul_unit_top
    import rv32m_pkg::*;
    import ooo_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // Dispatch, credit based
    input  logic        dispatch_valid,
    input  dispatch_t   dispatch,
    output logic        dispatch_credit,
    // Register file write port
    input  logic        rf_we,
    input  preg_t       rf_waddr,
    input  word_t       rf_wdata,
    // CDB, credit based
    output logic        cdb_valid,
    output cdb_packet_t cdb,
    input  logic        cdb_credit
);

    preg_t       rs1_tag;
    preg_t       rs2_tag;
    word_t       rs1_data;
    word_t       rs2_data;
    logic        fu_ready;
    fu_input_t   issue;
    logic        res_valid;
    cdb_packet_t res;
    logic        res_accept;

    mul_station u_station (
        .clk             (clk),
        .rst             (rst),
        .dispatch_valid  (dispatch_valid),
        .dispatch        (dispatch),
        .dispatch_credit (dispatch_credit),
        .rs1_tag         (rs1_tag),
        .rs2_tag         (rs2_tag),
        .fu_ready        (fu_ready),
        .issue           (issue)
    );

    // Station head tags index the read ports
    phys_regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (rs1_tag),
        .raddr2 (rs2_tag),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    fu_wrapper_mult u_fu (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .fu_ready   (fu_ready),
        .res_valid  (res_valid),
        .res        (res),
        .res_accept (res_accept)
    );

    cdb_credit_out u_cdb_out (
        .clk        (clk),
        .rst        (rst),
        .res_valid  (res_valid),
        .res        (res),
        .res_accept (res_accept),
        .cdb_valid  (cdb_valid),
        .cdb        (cdb),
        .cdb_credit (cdb_credit)
    );

endmodule

// ==== test/mul_unit_chk.sv ====
`timescale 1ns/1ps
`include "ooo_settings.svh"

module mul_unit_chk (
    input logic                                clk,
    input logic                                rst,
    input logic                                start_calculate,
    input logic                                fu_ready,
    input logic                                res_valid,
    input logic                                res_accept,
    input logic                                cdb_valid,
    input logic                                cdb_credit,
    input logic [$clog2(`CDB_CREDITS + 1)-1:0] credit_cnt
);

    // Unit occupancy seen from the issue and result handshakes
    logic unit_busy;
    // Credits held by the buffer as counted from the bus side
    int   bus_credits;

    always_ff @(posedge clk) begin
        if (rst) begin
            unit_busy <= 1'b0;
        end else if (start_calculate) begin
            unit_busy <= 1'b1;
        end else if (res_valid && res_accept) begin
            unit_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_credits <= `CDB_CREDITS;
        end else begin
            bus_credits <= bus_credits + int'(cdb_credit) - int'(cdb_valid);
        end
    end

    // Station issues only into an idle unit
    a_issue_ready: assert property (@(posedge clk) disable iff (rst)
        start_calculate |-> (fu_ready && !unit_busy))
        else $error("start_calculate while the unit still holds an instruction");

    // Buffer count follows the bus and never drops below zero
    a_credit_range: assert property (@(posedge clk) disable iff (rst)
        (bus_credits >= 0) && (int'(credit_cnt) == bus_credits))
        else $error("CDB credit count negative or out of step with the bus");

    // Every packet on the bus needs a credit in hand
    a_send_credit: assert property (@(posedge clk) disable iff (rst)
        cdb_valid |-> (bus_credits > 0))
        else $error("cdb_valid with no CDB credit");

endmodule

bind mul_unit_top mul_unit_chk chk0 (
    .clk             (clk),
    .rst             (rst),
    .start_calculate (issue.start_calculate),
    .fu_ready        (fu_ready),
    .res_valid       (res_valid),
    .res_accept      (res_accept),
    .cdb_valid       (cdb_valid),
    .cdb_credit      (cdb_credit),
    .credit_cnt      (u_cdb_out.credit_cnt)
);

// ==== test/mul_unit_tb.sv ====
`timescale 1ns/1ps
`include "ooo_settings.svh"

module mul_unit_tb
    import rv32m_pkg::*;
    import ooo_pkg::*;
();

    localparam int N_CORNER    = 20;
    localparam int N_RANDOM    = 20;
    // Fills CDB window, FIFO, unit and station while credits are held back
    localparam int N_HOLD      = 2 * `CDB_CREDITS + 1 + `MUL_RS_DEPTH;
    localparam int N_INST      = N_CORNER + N_RANDOM + N_HOLD + `MUL_RS_DEPTH;
    localparam int HOLD_WINDOW = 120;
    // About 40 cycles per multiply plus register load and the stall window
    localparam int WATCHDOG_NS = N_INST * 40 * 4 + (HOLD_WINDOW + `NUM_PREGS) * 4 + 2000;

    logic        clk;
    logic        rst;
    logic        dispatch_valid;
    dispatch_t   dispatch;
    logic        dispatch_credit;
    logic        rf_we;
    preg_t       rf_waddr;
    word_t       rf_wdata;
    logic        cdb_valid;
    cdb_packet_t cdb;
    logic        cdb_credit;

    logic [31:0] lcg_state;
    word_t       shadow [`NUM_PREGS];
    cdb_packet_t exp_q [$];
    string       name_q [$];
    // Cycle numbers at which a CDB credit goes back
    int          due_q [$];
    int          last_due;
    int          cycle;
    int          disp_credits;
    int          credits_back;
    int          sent;
    int          hold_seen;
    bit          hold_credits;

    mul_unit_top dut0 (
        .clk             (clk),
        .rst             (rst),
        .dispatch_valid  (dispatch_valid),
        .dispatch        (dispatch),
        .dispatch_credit (dispatch_credit),
        .rf_we           (rf_we),
        .rf_waddr        (rf_waddr),
        .rf_wdata        (rf_wdata),
        .cdb_valid       (cdb_valid),
        .cdb             (cdb),
        .cdb_credit      (cdb_credit)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper bits only since the low LCG bits cycle too fast
    function automatic int rand_below(input int n);
        return int'(next_rand() >> 8) % n;
    endfunction

    function automatic word_t corner_value(input int i);
        case (i)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'hffff_ffff;
            3:       return 32'h8000_0000;
            default: return 32'h7fff_ffff;
        endcase
    endfunction

    // Expected result from the ISA definition
    // Both operands extended to 64 bits so the product wraps into the right value
    function automatic word_t ref_mul(input mul_op_e op, input word_t a, input word_t b);
        dword_t ea;
        dword_t eb;
        dword_t full;
        ea   = (op != MULHU) ? {{`XLEN{a[`XLEN-1]}}, a} : {{`XLEN{1'b0}}, a};
        eb   = (op == MUL || op == MULH) ? {{`XLEN{b[`XLEN-1]}}, b} : {{`XLEN{1'b0}}, b};
        full = ea * eb;
        return (op == MUL) ? full[`XLEN-1:0] : full[2*`XLEN-1:`XLEN];
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    // One dispatch that spends a credit and queues the expected packet
    task automatic send_inst(input string name, input mul_op_e op, input preg_t rs1,
                             input preg_t rs2, input preg_t rd, input rob_idx_t rob);
        dispatch_t   d;
        cdb_packet_t e;
        @(posedge clk);
        #1;
        while (disp_credits == 0) begin
            dispatch_valid = 1'b0;
            @(posedge clk);
            #1;
        end
        d.op      = op;
        d.rs1     = rs1;
        d.rs2     = rs2;
        d.rd      = rd;
        d.rob_idx = rob;
        e.rd      = rd;
        e.rob_idx = rob;
        e.value   = ref_mul(op, shadow[rs1], shadow[rs2]);
        exp_q.push_back(e);
        name_q.push_back(name);
        dispatch       = d;
        dispatch_valid = 1'b1;
        disp_credits--;
        sent++;
    endtask

    task automatic send_random(input string tag, input int idx);
        mul_op_e op;
        op = mul_op_e'(rand_below(4));
        send_inst($sformatf("%s_%s_%0d", tag, op.name(), idx), op,
                  preg_t'(rand_below(`NUM_PREGS)), preg_t'(rand_below(`NUM_PREGS)),
                  preg_t'(rand_below(`NUM_PREGS)), rob_idx_t'(rand_below(`ROB_DEPTH)));
    endtask

    task automatic end_dispatch();
        @(posedge clk);
        #1;
        dispatch_valid = 1'b0;
    endtask

    // All results out and all CDB credits handed back
    task automatic wait_drain();
        end_dispatch();
        while (exp_q.size() != 0 || due_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    // p1..p5 hold the corner operands and the rest are random
    task automatic load_regs();
        word_t v;
        for (int r = 0; r < `NUM_PREGS; r++) begin
            if (r >= 1 && r <= 5) begin
                v = corner_value(r - 1);
            end else begin
                v = next_rand();
            end
            @(posedge clk);
            #1;
            rf_we    = 1'b1;
            rf_waddr = preg_t'(r);
            rf_wdata = v;
            // p0 write is dropped since it always reads zero
            if (r != 0) begin
                shadow[r] = v;
            end
        end
        @(posedge clk);
        #1;
        rf_we = 1'b0;
        @(posedge clk);
    endtask

    task automatic run_corners();
        mul_op_e op;
        for (int o = 0; o < 4; o++) begin
            op = mul_op_e'(o);
            // Partner corner shifts with the op
            for (int i = 0; i < 5; i++) begin
                send_inst($sformatf("corner_%s_%0d", op.name(), i), op,
                          preg_t'(1 + i), preg_t'(1 + (i + o) % 5),
                          preg_t'(8 + o * 5 + i), rob_idx_t'(o * 5 + i));
            end
        end
        wait_drain();
    endtask

    task automatic run_credit_hold();
        wait_drain();
        // Away from both the credit drive point and the monitor edge
        @(posedge clk);
        #3;
        hold_credits = 1'b1;
        hold_seen    = 0;
        for (int k = 0; k < N_HOLD; k++) begin
            send_random("hold", k);
        end
        end_dispatch();
        while (hold_seen < `CDB_CREDITS) begin
            @(posedge clk);
        end
        repeat (HOLD_WINDOW) @(posedge clk);
        assert (hold_seen == `CDB_CREDITS)
            else fail_now("more CDB packets than credits while credits were held back");
        assert (disp_credits == 0)
            else fail_now("dispatch credits still available with the pipeline full");
        @(posedge clk);
        #3;
        hold_credits = 1'b0;
        wait_drain();
    endtask

    task automatic run_depth();
        int base;
        base = credits_back;
        for (int k = 0; k < `MUL_RS_DEPTH; k++) begin
            send_random("depth", k);
        end
        wait_drain();
        assert (credits_back - base == `MUL_RS_DEPTH)
            else fail_now($sformatf("MISMATCH depth_credits expected %0d actual %0d",
                                    `MUL_RS_DEPTH, credits_back - base));
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Credit counting at the dispatch side
    always @(negedge clk) begin
        if (!rst && dispatch_credit) begin
            disp_credits++;
            credits_back++;
            assert (disp_credits <= `MUL_RS_DEPTH)
                else fail_now("station returned more dispatch credits than it was given");
        end
    end

    // Scoreboard in dispatch order
    always @(negedge clk) begin : cdb_compare
        cdb_packet_t exp_pkt;
        string       name;
        int          due;
        if (!rst && cdb_valid) begin
            assert (sent != 0) else fail_now("cdb_valid raised before any dispatch");
            assert (exp_q.size() != 0) else fail_now("CDB packet with nothing outstanding");
            exp_pkt = exp_q.pop_front();
            name    = name_q.pop_front();
            assert (cdb.value == exp_pkt.value)
                else fail_now($sformatf("MISMATCH %s value expected %h actual %h",
                                        name, exp_pkt.value, cdb.value));
            assert (cdb.rd == exp_pkt.rd)
                else fail_now($sformatf("MISMATCH %s rd expected %0d actual %0d",
                                        name, exp_pkt.rd, cdb.rd));
            assert (cdb.rob_idx == exp_pkt.rob_idx)
                else fail_now($sformatf("MISMATCH %s rob_idx expected %0d actual %0d",
                                        name, exp_pkt.rob_idx, cdb.rob_idx));
            if (hold_credits) begin
                hold_seen++;
            end
            // Credit comes back 0 to 6 cycles later and in order
            due = cycle + 1 + rand_below(7);
            if (due < last_due) begin
                due = last_due;
            end
            due_q.push_back(due);
            last_due = due;
        end
    end

    // One credit pulse per cycle at most
    initial begin
        cdb_credit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            cdb_credit = 1'b0;
            if (!hold_credits && due_q.size() != 0 && due_q[0] <= cycle) begin
                cdb_credit = 1'b1;
                void'(due_q.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_now($sformatf("watchdog expired after %0d ns", WATCHDOG_NS));
    end

    initial begin
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        rf_we          = 1'b0;
        rf_waddr       = '0;
        rf_wdata       = '0;
        lcg_state      = 32'd39;
        shadow[0]      = '0;
        last_due       = 0;
        disp_credits   = `MUL_RS_DEPTH;
        credits_back   = 0;
        sent           = 0;
        hold_seen      = 0;
        hold_credits   = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        // cdb must stay quiet during the register load
        load_regs();
        run_corners();
        for (int k = 0; k < N_RANDOM; k++) begin
            send_random("random", k);
        end
        wait_drain();
        run_credit_hold();
        run_depth();
        assert (credits_back == sent)
            else fail_now($sformatf("MISMATCH dispatch_credits expected %0d actual %0d",
                                    sent, credits_back));
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+common
common/rv32m_pkg.sv
common/ooo_pkg.sv
src/phys_regfile.sv
mul_station/mul_station.sv
mul_fu/shift_add_multiplier.sv
mul_fu/fu_wrapper_mult.sv
src/cdb_credit_out.sv
src/mul_unit_top.sv
test/mul_unit_chk.sv
test/mul_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module mul_unit_tb -f tb.f -o mul_unit_sim

./obj_dir/mul_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "Regression passed" sim.log; then
    echo "Simulation ended without a verdict"
    exit 1
fi
echo "Simulation PASSED"
